// ==== fast_read_top.f ====
design/fast_read_pkg.sv
design/read_sequencer.sv
design/packet_gate.sv
design/bank_scan.sv
design/sample_mux.sv
design/fast_read_top.sv
testbench/fast_read_sva.sv
testbench/tb_fast_read_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fast read testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_exe="$build_dir/Vtb_fast_read_top"

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_fast_read_top \
        --Mdir "$build_dir" \
        -f fast_read_top.f; then
    echo "verilator build failed"
    exit 1
fi

"$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "=== FAIL ===" "$log_file"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "=== PASS ===" "$log_file"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== testbench/tb_fast_read_top.sv ====
// Address width cut to 5 bits so a readout is 32 rows; bank data is a fixed bank/address pattern
`timescale 1ns/100ps
module tb_fast_read_top;
    import fast_read_pkg::*;

    localparam int tb_addr_w = 5;
    localparam int rows      = 1 << tb_addr_w;
    localparam int idle_max  = 16;
    // Seven wide runs, one narrow run and at most 30 packet gaps
    localparam int total_steps = 7 * rows * wide_row_len + rows * narrow_row_len
                                 + 30 * idle_max;
    // About 2.9 cycles per step at 70 percent strobes, doubled
    localparam int cycle_limit = total_steps * 6 + 2000;

    logic                  clk;
    logic                  rstn;
    logic                  capture_start;
    logic                  capture_again;
    logic                  wide_mode;
    pkt_len_t              pkt_len;
    logic [idle_len_w-1:0] idle_len;
    logic                  data_rd_en;
    logic                  fast_read_en;
    bank_bus_t             fast_din;
    bank_sel_t             chip_en;
    logic [tb_addr_w-1:0]  fast_addr;
    logic                  fast_rd_done;
    sample_t               adc_data;
    logic                  adc_data_valid;

    sample_t got_q[$];
    sample_t exp_q[$];
    int      burst_q[$];
    int      gap_q[$];
    int      cur_burst;
    int      last_step_strobes;
    bit      first_in_run;
    int      strobe_total;
    int      strobe_hist[3];
    int      cycle_cnt;
    int      errors;
    int      checks;
    int      tests_run;
    int      tests_failed;

    fast_read_top #(
        .addr_w(tb_addr_w)
    ) fast_read_top_inst (
        .clk            (clk),
        .rstn           (rstn),
        .capture_start  (capture_start),
        .capture_again  (capture_again),
        .wide_mode      (wide_mode),
        .pkt_len        (pkt_len),
        .idle_len       (idle_len),
        .data_rd_en     (data_rd_en),
        .fast_read_en   (fast_read_en),
        .fast_din       (fast_din),
        .chip_en        (chip_en),
        .fast_addr      (fast_addr),
        .fast_rd_done   (fast_rd_done),
        .adc_data       (adc_data),
        .adc_data_valid (adc_data_valid)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------------------
    // Capture memory and reference model
    // ----------------------------------------------------------------------
    // Bank number in the top bits, address in the middle
    function automatic bank_word_t mem_word(input int b, input logic [tb_addr_w-1:0] a);
        bank_word_t w;
        w.hi = {5'(b), a, 8'(a * 7 + b)};
        w.lo = {5'(b), ~a, 8'(b * 11 + a)};
        return w;
    endfunction

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            fast_din[b] = mem_word(b, fast_addr);
        end
    end

    function automatic void build_expected(input bit wide);
        int         nb;
        bank_word_t w;
        nb = wide ? num_banks : narrow_banks;
        exp_q.delete();
        for (int a = 0; a < rows; a++) begin
            for (int b = 0; b < nb; b++) begin
                w = mem_word(b, tb_addr_w'(a));
                exp_q.push_back(w.hi);
                exp_q.push_back(w.lo);
            end
        end
    endfunction

    // ----------------------------------------------------------------------
    // Monitor
    // ----------------------------------------------------------------------
    // Two strobes per step inside a packet, so a wider spacing is a gap
    function automatic void track_burst(input int step_strobes);
        int diff;
        if (first_in_run) begin
            first_in_run = 1'b0;
            cur_burst    = 1;
        end else begin
            diff = step_strobes - last_step_strobes;
            if (diff > 2) begin
                burst_q.push_back(cur_burst);
                gap_q.push_back(diff / 2 - 1);
                cur_burst = 1;
            end else begin
                cur_burst++;
            end
        end
        last_step_strobes = step_strobes;
    endfunction

    // Valid trails its step by two cycles, hence the strobe history
    always @(posedge clk) begin
        strobe_total   = strobe_total + int'(data_rd_en);
        strobe_hist[2] = strobe_hist[1];
        strobe_hist[1] = strobe_hist[0];
        strobe_hist[0] = strobe_total;
        if (rstn && adc_data_valid) begin
            got_q.push_back(adc_data);
            track_burst(strobe_hist[2]);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic compare_sample(input sample_t got, input sample_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t sample %0d: got %05h expected %05h", $time, idx, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_done(input bit got, input bit exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0b expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_samples(input bit wide);
        int n;
        build_expected(wide);
        compare_count(got_q.size(), exp_q.size(), "sample count");
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            compare_sample(got_q[i], exp_q[i], i);
        end
    endtask

    function automatic void report_test(input string name, input int err_mark);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - err_mark);
        end else begin
            $display("test %0d %s: ok, %0d samples", tests_run, name, got_q.size());
        end
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    task automatic clear_done(input bit again);
        @(negedge clk);
        if (again) begin
            capture_again = 1'b1;
        end else begin
            capture_start = 1'b1;
        end
        @(negedge clk);
        capture_start = 1'b0;
        capture_again = 1'b0;
    endtask

    // One full readout; gate_at > 0 holds strobes low for gate_len cycles mid-run
    task automatic run_readout(input bit wide, input int idle, input pkt_len_t plen,
                               input int gate_at, input int gate_len);
        bit                   done_seen;
        bit                   gated;
        int                   n_hold;
        int                   moved;
        logic [tb_addr_w-1:0] addr_hold;
        done_seen = 1'b0;
        gated     = 1'b0;
        @(negedge clk);
        got_q.delete();
        burst_q.delete();
        gap_q.delete();
        first_in_run = 1'b1;
        cur_burst    = 0;
        wide_mode    = wide;
        idle_len     = idle_len_w'(idle);
        pkt_len      = plen;
        fast_read_en = 1'b1;
        @(negedge clk);
        fast_read_en = 1'b0;
        while (!done_seen) begin
            if (gate_at > 0 && !gated && got_q.size() >= gate_at) begin
                // Let in-flight samples drain first
                data_rd_en = 1'b0;
                repeat (3) @(negedge clk);
                n_hold    = got_q.size();
                addr_hold = fast_addr;
                moved     = 0;
                repeat (gate_len) begin
                    @(negedge clk);
                    if (fast_addr !== addr_hold) begin
                        moved++;
                    end
                end
                compare_count(got_q.size(), n_hold, "samples while strobes low");
                compare_count(moved, 0, "address changes while strobes low");
                gated = 1'b1;
            end
            data_rd_en = ($urandom_range(9, 0) < 7);
            @(negedge clk);
            done_seen = fast_rd_done;
        end
        data_rd_en = 1'b0;
        repeat (4) @(negedge clk);
        if (cur_burst > 0) begin
            burst_q.push_back(cur_burst);
        end
        compare_done(fast_rd_done, 1'b1, "done after last row");
    endtask

    initial begin
        int err_mark;
        int idle;
        int bad;
        int row_len;
        int rows_per_pkt;
        int hold;
        bit wide;
        clk           = 1'b0;
        rstn          = 1'b0;
        capture_start = 1'b0;
        capture_again = 1'b0;
        wide_mode     = 1'b1;
        pkt_len       = pkt_len_2;
        idle_len      = '0;
        data_rd_en    = 1'b0;
        fast_read_en  = 1'b0;
        void'($urandom(14064));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        err_mark = errors;
        compare_count($countones(chip_en), 0, "chip enables after reset");
        compare_done(adc_data_valid, 1'b0, "valid after reset");
        compare_done(fast_rd_done, 1'b0, "done after reset");
        run_readout(1'b1, 0, pkt_len_2, 0, 0);
        check_samples(1'b1);
        compare_count(burst_q.size(), 1, "bursts in continuous mode");
        report_test("continuous wide", err_mark);

        err_mark = errors;
        clear_done(1'b0);
        compare_done(fast_rd_done, 1'b0, "done cleared by capture_start");
        run_readout(1'b0, 0, pkt_len_2, 0, 0);
        check_samples(1'b0);
        bad = 0;
        foreach (got_q[i]) begin
            if (got_q[i][sample_w-1 -: 5] >= narrow_banks) begin
                bad++;
            end
        end
        compare_count(bad, 0, "samples from banks above 11");
        report_test("narrow", err_mark);

        err_mark = errors;
        for (int p = 0; p < 4; p++) begin
            idle         = $urandom_range(idle_max, 1);
            wide         = $urandom_range(1, 0);
            row_len      = wide ? wide_row_len : narrow_row_len;
            rows_per_pkt = 2 << p;
            clear_done(1'b0);
            run_readout(wide, idle, pkt_len_t'(p), 0, 0);
            check_samples(wide);
            compare_count(burst_q.size(), rows / rows_per_pkt, "burst count");
            foreach (burst_q[i]) begin
                compare_count(burst_q[i], rows_per_pkt * row_len, "burst length");
            end
            bad = 0;
            foreach (gap_q[i]) begin
                if (gap_q[i] < idle) begin
                    bad++;
                end
            end
            compare_count(bad, 0, "gaps shorter than idle_len");
        end
        report_test("packet mode", err_mark);

        err_mark = errors;
        hold = $urandom_range(20, 5);
        repeat (hold) begin
            @(negedge clk);
            compare_done(fast_rd_done, 1'b1, "done held before capture_again");
        end
        clear_done(1'b1);
        compare_done(fast_rd_done, 1'b0, "done cleared by capture_again");
        run_readout(1'b1, 0, pkt_len_2, 0, 0);
        check_samples(1'b1);
        report_test("done and restart", err_mark);

        err_mark = errors;
        clear_done(1'b0);
        run_readout(1'b1, 0, pkt_len_2, $urandom_range(1200, 100), $urandom_range(60, 20));
        check_samples(1'b1);
        report_test("strobe gating", err_mark);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== testbench/fast_read_sva.sv ====
// Bank enable checks only; assumes wide_mode is changed only while the reader is idle
`timescale 1ns/100ps
module fast_read_sva (
    input logic                             clk,
    input logic                             rstn,
    input logic                             step,
    input logic                             pkt_open,
    input logic [fast_read_pkg::slot_w-1:0] slot,
    input logic                             wide_mode,
    input fast_read_pkg::bank_sel_t         bank_sel
);
    import fast_read_pkg::*;

    // Every fetch step enables exactly one bank, so the slot never runs past the row
    onehot_bank: assert property (@(posedge clk) disable iff (!rstn)
        (step && pkt_open && !slot[0]) |=> $onehot(bank_sel))
        else $error("fetch step without exactly one bank enabled: %h", bank_sel);

    // Narrow rows never reach the upper twelve banks
    narrow_bank: assert property (@(posedge clk) disable iff (!rstn)
        !wide_mode |-> (bank_sel[num_banks-1:narrow_banks] == '0))
        else $error("upper bank enabled in narrow mode: %h", bank_sel);

    // Enable follows a step, and pacing keeps the next step at least two cycles away
    sel_after_step: assert property (@(posedge clk) disable iff (!rstn)
        (bank_sel != '0) |-> ($past(step) && !step))
        else $error("bank enabled without a preceding step: %h", bank_sel);

endmodule

bind bank_scan fast_read_sva fast_read_sva_inst (
    .clk       (clk),
    .rstn      (rstn),
    .step      (step),
    .pkt_open  (pkt_open),
    .slot      (slot),
    .wide_mode (wide_mode),
    .bank_sel  (bank_sel)
);

// ==== design/fast_read_top.sv ====
// Bank memories sit outside; their read data is expected combinationally on fast_addr and chip_en
`timescale 1ns/100ps
module fast_read_top #(
    parameter int addr_w = fast_read_pkg::addr_w_default
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 capture_start,
    input  logic                                 capture_again,
    input  logic                                 wide_mode,
    input  fast_read_pkg::pkt_len_t              pkt_len,
    input  logic [fast_read_pkg::idle_len_w-1:0] idle_len,
    input  logic                                 data_rd_en,
    input  logic                                 fast_read_en,
    input  fast_read_pkg::bank_bus_t             fast_din,
    output fast_read_pkg::bank_sel_t             chip_en,
    output logic [addr_w-1:0]                    fast_addr,
    output logic                                 fast_rd_done,
    output fast_read_pkg::sample_t               adc_data,
    output logic                                 adc_data_valid
);
    import fast_read_pkg::*;

    logic              reading;
    logic              continuous;
    logic              row_end;
    logic              last_row;
    logic              packet_end;
    logic              pkt_open;
    logic              step;
    logic [slot_w-1:0] slot;

    // ----------------------------------------------------------------------
    // Address, mode and done
    // ----------------------------------------------------------------------
    read_sequencer #(
        .addr_w(addr_w)
    ) read_sequencer_inst (
        .clk           (clk),
        .rstn          (rstn),
        .fast_read_en  (fast_read_en),
        .capture_start (capture_start),
        .capture_again (capture_again),
        .idle_len      (idle_len),
        .pkt_len       (pkt_len),
        .row_end       (row_end),
        .reading       (reading),
        .continuous    (continuous),
        .packet_end    (packet_end),
        .last_row      (last_row),
        .fast_addr     (fast_addr),
        .fast_rd_done  (fast_rd_done)
    );

    // Packet gaps
    packet_gate packet_gate_inst (
        .clk        (clk),
        .rstn       (rstn),
        .reading    (reading),
        .continuous (continuous),
        .idle_len   (idle_len),
        .step       (step),
        .packet_end (packet_end),
        .pkt_open   (pkt_open)
    );

    // Step pacing and bank enables
    bank_scan bank_scan_inst (
        .clk        (clk),
        .rstn       (rstn),
        .data_rd_en (data_rd_en),
        .reading    (reading),
        .pkt_open   (pkt_open),
        .wide_mode  (wide_mode),
        .step       (step),
        .slot       (slot),
        .row_end    (row_end),
        .bank_sel   (chip_en)
    );

    // Sample output
    sample_mux sample_mux_inst (
        .clk            (clk),
        .rstn           (rstn),
        .fast_din       (fast_din),
        .bank_sel       (chip_en),
        .step           (step),
        .pkt_open       (pkt_open),
        .adc_data       (adc_data),
        .adc_data_valid (adc_data_valid)
    );

endmodule

// ==== design/sample_mux.sv ====
// Bank data must be valid combinationally in the cycle its enable is high
`timescale 1ns/100ps
module sample_mux (
    input  logic                      clk,
    input  logic                      rstn,
    input  fast_read_pkg::bank_bus_t  fast_din,
    input  fast_read_pkg::bank_sel_t  bank_sel,
    input  logic                      step,
    input  logic                      pkt_open,
    output fast_read_pkg::sample_t    adc_data,
    output logic                      adc_data_valid
);
    import fast_read_pkg::*;

    bank_word_t sel_word;
    bank_word_t word_hold;
    logic       step_d;
    logic       half_lo;

    // One-hot select, so OR of the enabled words is enough
    always_comb begin
        sel_word = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (bank_sel[b]) begin
                sel_word = sel_word | fast_din[b];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            step_d         <= 1'b0;
            half_lo        <= 1'b0;
            adc_data_valid <= 1'b0;
        end else begin
            // Only steps inside an open packet carry a sample
            step_d         <= step & pkt_open;
            adc_data_valid <= step_d;
            if (step_d) begin
                half_lo <= ~half_lo;
            end else if (!pkt_open) begin
                half_lo <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Payload
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (bank_sel != '0) begin
            word_hold <= sel_word;
        end
        // High half straight from the bank, low half from the held word
        if (step_d) begin
            adc_data <= half_lo ? word_hold.lo : sel_word.hi;
        end
    end

endmodule

// ==== design/bank_scan.sv ====
// Each step must see stable wide_mode; slot only advances inside an open packet
`timescale 1ns/100ps
module bank_scan (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             data_rd_en,
    input  logic                             reading,
    input  logic                             pkt_open,
    input  logic                             wide_mode,
    output logic                             step,
    output logic [fast_read_pkg::slot_w-1:0] slot,
    output logic                             row_end,
    output fast_read_pkg::bank_sel_t         bank_sel
);
    import fast_read_pkg::*;

    logic              pace;
    logic [slot_w-1:0] slot_last;
    logic              even_step;

    // ----------------------------------------------------------------------
    // Strobe pacing
    // ----------------------------------------------------------------------
    // Toggle flips on every strobe, so every second strobe becomes a step
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pace <= 1'b0;
        end else if (!reading) begin
            pace <= 1'b0;
        end else if (data_rd_en) begin
            pace <= ~pace;
        end
    end

    assign step = data_rd_en & pace & reading;

    // ----------------------------------------------------------------------
    // Sample slot within a row
    // ----------------------------------------------------------------------
    assign slot_last = wide_mode ? slot_w'(wide_row_len - 1) : slot_w'(narrow_row_len - 1);
    assign row_end   = step & pkt_open & (slot == slot_last);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot <= '0;
        end else if (!pkt_open) begin
            slot <= '0;
        end else if (row_end) begin
            slot <= '0;
        end else if (step) begin
            slot <= slot + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Bank enables
    // ----------------------------------------------------------------------
    // Even slots fetch a new word, odd slots use the held low half
    assign even_step = step & pkt_open & ~slot[0];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bank_sel <= '0;
        end else if (even_step) begin
            bank_sel <= bank_sel_t'(1) << slot[slot_w-1:1];
        end else begin
            bank_sel <= '0;
        end
    end

endmodule

// ==== design/packet_gate.sv ====
// idle_len is read live during a run; in packet mode it must be nonzero
`timescale 1ns/100ps
module packet_gate (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 reading,
    input  logic                                 continuous,
    input  logic [fast_read_pkg::idle_len_w-1:0] idle_len,
    input  logic                                 step,
    input  logic                                 packet_end,
    output logic                                 pkt_open
);
    import fast_read_pkg::*;

    pkt_state_t            state;
    logic [idle_len_w-1:0] idle_cnt;
    logic                  gap_done;

    // Last step of the idle gap
    assign gap_done = step && (idle_cnt == idle_len - 1'b1);

    // ----------------------------------------------------------------------
    // Gap and open FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= pkt_st_gap;
            idle_cnt <= '0;
        end else if (!reading) begin
            state    <= pkt_st_gap;
            idle_cnt <= '0;
        end else begin
            case (state)
                pkt_st_gap: begin
                    if (continuous) begin
                        // No gaps at all in continuous readout
                        state <= pkt_st_open;
                    end else if (gap_done) begin
                        state    <= pkt_st_open;
                        idle_cnt <= '0;
                    end else if (step) begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                pkt_st_open: begin
                    if (packet_end) begin
                        state <= pkt_st_gap;
                    end
                end
                default: state <= pkt_st_gap;
            endcase
        end
    end

    // Registered, follows the state directly
    assign pkt_open = (state == pkt_st_open);

endmodule

// ==== design/read_sequencer.sv ====
// Mode and packet length are sampled at start; a done level left high must be cleared while idle
`timescale 1ns/100ps
module read_sequencer #(
    parameter int addr_w = fast_read_pkg::addr_w_default
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 fast_read_en,
    input  logic                                 capture_start,
    input  logic                                 capture_again,
    input  logic [fast_read_pkg::idle_len_w-1:0] idle_len,
    input  fast_read_pkg::pkt_len_t              pkt_len,
    input  logic                                 row_end,
    output logic                                 reading,
    output logic                                 continuous,
    output logic                                 packet_end,
    output logic                                 last_row,
    output logic [addr_w-1:0]                    fast_addr,
    output logic                                 fast_rd_done
);
    import fast_read_pkg::*;

    read_state_t state;
    pkt_len_t    pkt_len_q;
    logic        run_end;
    logic [4:0]  pkt_mask;
    logic        pkt_boundary;

    // ----------------------------------------------------------------------
    // Read FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= rd_st_idle;
            pkt_len_q <= pkt_len_2;
            run_end   <= 1'b0;
        end else begin
            run_end <= 1'b0;
            case (state)
                rd_st_idle: begin
                    if (fast_read_en) begin
                        state     <= (idle_len == '0) ? rd_st_cont : rd_st_pkt;
                        pkt_len_q <= pkt_len;
                    end
                end
                rd_st_cont, rd_st_pkt: begin
                    // Back to idle one cycle after the final row
                    run_end <= row_end & last_row;
                    if (run_end) begin
                        state <= rd_st_idle;
                    end
                end
                default: state <= rd_st_idle;
            endcase
        end
    end

    assign reading    = (state != rd_st_idle);
    assign continuous = (state == rd_st_cont);

    // ----------------------------------------------------------------------
    // Address counter and done flag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fast_addr    <= '0;
            fast_rd_done <= 1'b0;
        end else if (state == rd_st_idle) begin
            if (capture_start | capture_again) begin
                fast_rd_done <= 1'b0;
            end
        end else if (row_end) begin
            // Wraps to zero after the last row
            fast_addr <= fast_addr + 1'b1;
            if (last_row) begin
                fast_rd_done <= 1'b1;
            end
        end
    end

    assign last_row = &fast_addr;

    // Packet ends when the low address bits for its length are all ones
    assign pkt_mask     = (5'd2 << pkt_len_q) - 5'd1;
    assign pkt_boundary = ((fast_addr & addr_w'(pkt_mask)) == addr_w'(pkt_mask));
    assign packet_end   = row_end & (state == rd_st_pkt) & pkt_boundary;

endmodule

// ==== design/fast_read_pkg.sv ====
// Bank count, sample width and row lengths are fixed here; the address width is set per instance
package fast_read_pkg;

    // ----------------------------------------------------------------------
    // Capture memory geometry
    // ----------------------------------------------------------------------
    localparam int num_banks      = 24;
    localparam int narrow_banks   = 12;
    localparam int addr_w_default = 15;

    // Sample and word widths
    localparam int sample_w    = 18;
    localparam int bank_word_w = 2 * sample_w;

    // Row lengths in samples, two samples per bank
    localparam int wide_row_len   = 2 * num_banks;
    localparam int narrow_row_len = 2 * narrow_banks;

    // Counter widths
    localparam int slot_w     = 6;
    localparam int idle_len_w = 16;

    // Packet length codes, rows per packet is 2 << code
    localparam logic [1:0] pkt_len_2  = 2'd0;
    localparam logic [1:0] pkt_len_4  = 2'd1;
    localparam logic [1:0] pkt_len_8  = 2'd2;
    localparam logic [1:0] pkt_len_16 = 2'd3;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------
    typedef logic [sample_w-1:0] sample_t;

    // High sample sits in the upper half of the word
    typedef struct packed {
        sample_t hi;
        sample_t lo;
    } bank_word_t;

    typedef logic [num_banks-1:0] bank_sel_t;

    // Bank 0 occupies the low bits
    typedef bank_word_t [num_banks-1:0] bank_bus_t;

    typedef logic [1:0] pkt_len_t;

    typedef enum logic [1:0] {rd_st_idle, rd_st_cont, rd_st_pkt} read_state_t;

    typedef enum logic {pkt_st_gap, pkt_st_open} pkt_state_t;

endpackage
